// File: src/acc_pkg.sv
`default_nettype none

package acc_pkg;

    // ======================================================================
    // Widths
    // ======================================================================

    // 16-bit products grown by an 8-way adder tree
    localparam int PSUM_W = 16 + $clog2(8);
    localparam int OUT_W  = 16;
    // Room for 256 partial sums without overflow
    localparam int ACC_W  = PSUM_W + 8;
    localparam int LEN_W  = 8;

    // ======================================================================
    // Types
    // ======================================================================

    typedef logic signed [PSUM_W-1:0] psum_t;
    typedef logic signed [ACC_W-1:0]  acc_t;
    typedef logic signed [OUT_W-1:0]  osum_t;

    // Group length or count, 0 stands for 256
    typedef logic [LEN_W-1:0] len_t;

    typedef enum logic {
        ACC_IDLE,
        ACC_GROUP
    } acc_state_t;

endpackage

`default_nettype wire

// File: src/acc_ctrl.sv
`default_nettype none

module acc_ctrl (
    input  wire           clk,
    input  wire           rstn,
    input  wire           acc_pkg::len_t cfg_acc_num,
    input  wire           idata_valid,
    input  wire           last,
    output acc_pkg::len_t grp_len,
    output logic          busy
);

    import acc_pkg::*;

    acc_state_t state;
    len_t       len_q;

    // ======================================================================
    // Group open / closed
    // ======================================================================

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= ACC_IDLE;
        end else begin
            case (state)
                ACC_IDLE: begin
                    // Single-input group opens and closes on the same edge
                    if (idata_valid && !last) begin
                        state <= ACC_GROUP;
                    end
                end
                ACC_GROUP: begin
                    if (last) begin
                        state <= ACC_IDLE;
                    end
                end
                default: begin
                    state <= ACC_IDLE;
                end
            endcase
        end
    end

    // Length is frozen at the first input of a group
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            len_q <= '0;
        end else if (state == ACC_IDLE && idata_valid) begin
            len_q <= cfg_acc_num;
        end
    end

    // Live config until a group opens
    assign grp_len = (state == ACC_GROUP) ? len_q : cfg_acc_num;

    assign busy = (state == ACC_GROUP);

endmodule

`default_nettype wire

// File: src/acc_count.sv
`default_nettype none

module acc_count (
    input  wire  clk,
    input  wire  rstn,
    input  wire  idata_valid,
    input  wire  acc_pkg::len_t grp_len,
    output logic last
);

    import acc_pkg::*;

    len_t cnt;
    len_t cnt_end;

    // Wraps modulo 256, so a length of 0 ends at count 255
    assign cnt_end = grp_len - len_t'(1);

    // Last-of-group strobe in the cycle of the accepted input
    assign last = idata_valid && (cnt == cnt_end);

    // ======================================================================
    // Accepted input counter
    // ======================================================================

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cnt <= '0;
        end else if (last) begin
            cnt <= '0;
        end else if (idata_valid) begin
            cnt <= cnt + len_t'(1);
        end
    end

endmodule

`default_nettype wire

// File: src/acc_mac.sv
`default_nettype none

module acc_mac (
    input  wire           clk,
    input  wire           rstn,
    input  wire           acc_pkg::psum_t idata,
    input  wire           idata_valid,
    input  wire           last,
    output acc_pkg::osum_t odata,
    output logic          odata_valid
);

    import acc_pkg::*;

    psum_t idata_q;
    logic  valid_q;
    logic  last_q;
    acc_t  acc;
    acc_t  acc_sum;

    // Clamp to the signed 16-bit range
    function automatic osum_t saturate(input acc_t value);
        logic fits;
        fits = (value[ACC_W-1:OUT_W-1] == {(ACC_W-OUT_W+1){value[ACC_W-1]}});
        if (fits) begin
            return value[OUT_W-1:0];
        end else if (value[ACC_W-1]) begin
            return {1'b1, {(OUT_W-1){1'b0}}};
        end else begin
            return {1'b0, {(OUT_W-1){1'b1}}};
        end
    endfunction

    // ======================================================================
    // Stage 1, input register
    // ======================================================================

    always_ff @(posedge clk) begin
        if (idata_valid) begin
            idata_q <= idata;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q <= 1'b0;
            last_q  <= 1'b0;
        end else begin
            valid_q <= idata_valid;
            last_q  <= last;
        end
    end

    // ======================================================================
    // Stage 2, accumulate and emit
    // ======================================================================

    // Sign-extended add of the registered partial sum
    assign acc_sum = acc + acc_t'(idata_q);

    // Cleared at the group boundary so the next group starts from zero
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            acc <= '0;
        end else if (last_q) begin
            acc <= '0;
        end else if (valid_q) begin
            acc <= acc_sum;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            odata       <= '0;
            odata_valid <= 1'b0;
        end else begin
            odata_valid <= last_q;
            if (last_q) begin
                odata <= saturate(acc_sum);
            end
        end
    end

endmodule

`default_nettype wire

// File: src/acc_top.sv
`default_nettype none

module acc_top (
    input  wire           clk,
    input  wire           rstn,
    input  wire           acc_pkg::len_t cfg_acc_num,
    input  wire           acc_pkg::psum_t idata,
    input  wire           idata_valid,
    output acc_pkg::osum_t odata,
    output logic          odata_valid,
    output logic          busy
);

    import acc_pkg::*;

    len_t grp_len;
    logic last;

    // ======================================================================
    // Group control
    // ======================================================================

    acc_ctrl u_ctrl (
        .clk         (clk),
        .rstn        (rstn),
        .cfg_acc_num (cfg_acc_num),
        .idata_valid (idata_valid),
        .last        (last),
        .grp_len     (grp_len),
        .busy        (busy)
    );

    acc_count u_count (
        .clk         (clk),
        .rstn        (rstn),
        .idata_valid (idata_valid),
        .grp_len     (grp_len),
        .last        (last)
    );

    // ======================================================================
    // Datapath
    // ======================================================================

    // Two edges from the last input to odata_valid
    acc_mac u_mac (
        .clk         (clk),
        .rstn        (rstn),
        .idata       (idata),
        .idata_valid (idata_valid),
        .last        (last),
        .odata       (odata),
        .odata_valid (odata_valid)
    );

endmodule

`default_nettype wire

// File: tests/acc_top_assert.sv
`default_nettype none

module acc_top_assert (
    input wire clk,
    input wire rstn,
    input wire last,
    input wire odata_valid,
    input wire busy
);

    timeunit 1ns;
    timeprecision 100ps;

    int fail_cnt = 0;

    // A second pulse in a row needs its own group end two edges back
    a_pulse_pair: assert property (@(posedge clk) disable iff (!rstn)
        odata_valid && $past(odata_valid) |-> $past(last, 2)
    ) else begin
        $error("odata_valid high twice in a row without a group end behind it");
        fail_cnt = fail_cnt + 1;
    end

    a_busy_reset: assert property (@(posedge clk) !rstn |-> !busy)
    else begin
        $error("busy high while reset is asserted");
        fail_cnt = fail_cnt + 1;
    end

    // Every group end yields a pulse two edges later
    a_latency: assert property (@(posedge clk) disable iff (!rstn)
        $past(last, 2) |-> odata_valid
    ) else begin
        $error("odata_valid missing two edges after the last strobe");
        fail_cnt = fail_cnt + 1;
    end

endmodule

`default_nettype wire

// File: tests/acc_checker.sv
`default_nettype none

module acc_checker (
    input  wire                 clk,
    input  wire                 rstn,
    input  wire acc_pkg::len_t  cfg_acc_num,
    input  wire acc_pkg::psum_t idata,
    input  wire                 idata_valid,
    input  wire acc_pkg::osum_t odata,
    input  wire                 odata_valid,
    input  wire                 busy,
    input  int                  test_idx,
    input  wire                 test_run,
    output int                  total_errors,
    output int                  tests_done
);

    timeunit 1ns;
    timeprecision 100ps;

    import acc_pkg::*;

    osum_t  exp_q[$];
    int     due_q[$];
    int     cycle;
    int     test_errors;
    logic   run_q;
    logic   grp_open;
    int     cap_len;
    int     count;
    longint sum;
    osum_t  exp_sum;
    int     due;

    // Signed 16-bit clamp of the exact group sum
    function automatic osum_t clamp_sum(input longint s);
        longint hi;
        hi = (longint'(1) <<< (OUT_W - 1)) - 1;
        if (s > hi) begin
            return osum_t'(hi);
        end else if (s < -hi - 1) begin
            return osum_t'(-hi - 1);
        end
        return osum_t'(s);
    endfunction

    task automatic note_error();
        test_errors++;
        total_errors++;
    endtask

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (!rstn) begin
            cycle = 0;
            test_errors = 0;
            total_errors = 0;
            tests_done = 0;
            run_q = 1'b0;
            grp_open = 1'b0;
            count = 0;
            sum = 0;
            exp_q.delete();
            due_q.delete();
        end else begin
            if (busy !== grp_open) begin
                $display("Mismatch busy: expected 0x%h, got 0x%h", grp_open, busy);
                note_error();
            end
            if (odata_valid) begin
                if (exp_q.size() == 0) begin
                    $display("Output pulse at cycle %0d with no completed group pending", cycle);
                    note_error();
                end else begin
                    exp_sum = exp_q.pop_front();
                    due = due_q.pop_front();
                    if (odata !== exp_sum) begin
                        $display("Mismatch odata: expected 0x%h, got 0x%h", exp_sum, odata);
                        note_error();
                    end
                    if (due != cycle) begin
                        $display("Group sum came out at cycle %0d instead of cycle %0d",
                                 cycle, due);
                        note_error();
                    end
                end
            end
            // Model: length frozen at the first input, 0 means 256
            if (idata_valid) begin
                if (!grp_open) begin
                    cap_len = (cfg_acc_num == '0) ? 256 : int'(cfg_acc_num);
                end
                sum = sum + longint'(idata);
                count++;
                if (count == cap_len) begin
                    exp_q.push_back(clamp_sum(sum));
                    due_q.push_back(cycle + 2);
                    sum = 0;
                    count = 0;
                    grp_open = 1'b0;
                end else begin
                    grp_open = 1'b1;
                end
            end
            if (test_run && !run_q) begin
                test_errors = 0;
            end
            if (!test_run && run_q) begin
                if (exp_q.size() != 0) begin
                    $display("%0d group sums never came out in test %0d", exp_q.size(), test_idx);
                    note_error();
                end
                $display("Test %0d done: %0d errors", test_idx, test_errors);
                tests_done++;
            end
            run_q = test_run;
        end
    end

endmodule

`default_nettype wire

// File: tests/tb_acc_top.sv
`default_nettype none

module tb_acc_top;

    timeunit 1ns;
    timeprecision 100ps;

    import acc_pkg::*;

    logic        clk;
    logic        rstn;
    len_t        cfg_acc_num;
    psum_t       idata;
    logic        idata_valid;
    osum_t       odata;
    logic        odata_valid;
    logic        busy;
    int          test_idx;
    logic        test_run;
    int          total_errors;
    int          tests_done;
    int          errors;
    int          cycles = 0;
    logic [31:0] lfsr;

    acc_top u_dut (
        .clk         (clk),
        .rstn        (rstn),
        .cfg_acc_num (cfg_acc_num),
        .idata       (idata),
        .idata_valid (idata_valid),
        .odata       (odata),
        .odata_valid (odata_valid),
        .busy        (busy)
    );

    bind acc_top acc_top_assert u_assert (
        .clk         (clk),
        .rstn        (rstn),
        .last        (last),
        .odata_valid (odata_valid),
        .busy        (busy)
    );

    acc_checker u_checker (
        .clk          (clk),
        .rstn         (rstn),
        .cfg_acc_num  (cfg_acc_num),
        .idata        (idata),
        .idata_valid  (idata_valid),
        .odata        (odata),
        .odata_valid  (odata_valid),
        .busy         (busy),
        .test_idx     (test_idx),
        .test_run     (test_run),
        .total_errors (total_errors),
        .tests_done   (tests_done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    // ======================================================================
    // Stimulus helpers
    // ======================================================================

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // Mode 0 small, 1 near max, 2 near min, 3 full range
    function automatic psum_t make_psum(input int mode);
        psum_t       pmax;
        psum_t       pmin;
        logic [31:0] r;
        pmax = {1'b0, {(PSUM_W-1){1'b1}}};
        pmin = {1'b1, {(PSUM_W-1){1'b0}}};
        if (mode == 1) begin
            return pmax - psum_t'(draw_bits(10));
        end else if (mode == 2) begin
            return pmin + psum_t'(draw_bits(10));
        end else if (mode == 3) begin
            return psum_t'(draw_bits(PSUM_W));
        end
        r = draw_bits(12);
        return psum_t'($signed(r[11:0]));
    endfunction

    // Per-input worst case is one cycle plus the largest gap
    function automatic int worst_case_cycles();
        int total;
        total = 10 + 5 * 8;
        total += 24 * 4;
        total += 2 * 256 * 4;
        total += 12 * 255 * 4;
        total += 8 * 16;
        total += 2 * (31 + 8) * 2;
        return total + 500;
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic send_group(input int len, input int gap_bits, input int mode);
        int gap;
        for (int i = 0; i < len; i++) begin
            idata = make_psum(mode);
            idata_valid = 1'b1;
            wait_cycles(1);
            idata_valid = 1'b0;
            gap = (gap_bits > 0) ? int'(draw_bits(gap_bits)) : 0;
            wait_cycles(gap);
        end
    endtask

    task automatic begin_test(input int idx);
        test_idx = idx;
        test_run = 1'b1;
        wait_cycles(1);
    endtask

    // Drain the two-edge output pipeline before closing the test
    task automatic end_test();
        wait_cycles(4);
        test_run = 1'b0;
        wait_cycles(2);
    endtask

    // ======================================================================
    // Tests
    // ======================================================================

    task automatic run_tests();
        int len;
        int first;
        begin_test(1);
        cfg_acc_num = len_t'(1);
        send_group(24, 2, 3);
        end_test();
        begin_test(2);
        cfg_acc_num = '0;
        send_group(256, 2, 0);
        send_group(256, 2, 0);
        end_test();
        begin_test(3);
        repeat (12) begin
            len = int'(draw_bits(8));
            len = (len == 0) ? 1 : len;
            cfg_acc_num = len_t'(len);
            send_group(len, 2, 0);
        end
        end_test();
        // Alternating sign, no idle cycle between groups
        begin_test(4);
        for (int i = 0; i < 8; i++) begin
            len = 1 + int'(draw_bits(4));
            cfg_acc_num = len_t'(len);
            send_group(len, 0, (i % 2) + 1);
        end
        end_test();
        begin_test(5);
        repeat (2) begin
            first = 16 + int'(draw_bits(4));
            cfg_acc_num = len_t'(first);
            send_group(first / 2, 1, 0);
            len = 1 + int'(draw_bits(3));
            cfg_acc_num = len_t'(len);
            send_group(first - first / 2, 1, 0);
            send_group(len, 1, 0);
        end
        end_test();
    endtask

    initial begin
        wait (cycles >= worst_case_cycles());
        $display("Timeout after %0d cycles with %0d tests done", cycles, tests_done);
        $display("Regression failed");
        $finish;
    end

    initial begin
        rstn = 1'b0;
        cfg_acc_num = '0;
        idata = '0;
        idata_valid = 1'b0;
        test_idx = 0;
        test_run = 1'b0;
        lfsr = 32'h5211_964e;
        repeat (10) @(posedge clk);
        #1;
        rstn = 1'b1;
        wait_cycles(2);
        run_tests();
        wait (tests_done == 5);
        errors = total_errors + u_dut.u_assert.fail_cnt;
        $display("Tests run: %0d, total errors: %0d", tests_done, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
src/acc_pkg.sv
src/acc_ctrl.sv
src/acc_count.sv
src/acc_mac.sv
src/acc_top.sv
tests/acc_top_assert.sv
tests/acc_checker.sv
tests/tb_acc_top.sv

// File: run.sh
#!/bin/sh
# Build and run the accumulator testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_acc_top -Mdir "$BUILD_DIR" -f sources.f
if [ $? -ne 0 ]; then
    echo "Verilator build did not complete"
    exit 1
fi

"./$BUILD_DIR/Vtb_acc_top" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Regression failed" "$LOG"; then
    exit 1
fi
exit 0
